// ==== logic/bemon_pkg.sv ====
`default_nettype none

package bemon_pkg;

    localparam int TLB_ENTRIES = 8;     // fully associative dtlb
    localparam int WINDOW_SIZE = 4;     // collision window in cycles, flush cycle included
    localparam int CNT_W       = 16;    // every event counter saturates at this width
    localparam int PPN_W       = 44;    // sv39 physical page number

    // flag positions inside the low byte of an sv39 pte
    localparam int PTE_V_BIT = 0;
    localparam int PTE_R_BIT = 1;
    localparam int PTE_W_BIT = 2;
    localparam int PTE_X_BIT = 3;
    localparam int PTE_A_BIT = 6;
    localparam int PTE_D_BIT = 7;

    localparam int WB_ADR_W   = 5;      // word address, counters live at 0 to 15
    localparam int WB_DAT_W   = 32;
    localparam int STATUS_ADR = 16;     // dtlb occupancy status word

    typedef enum logic [3:0] {
        FLT_NONE          = 4'd0,
        FLT_INVALID       = 4'd1,       // v flag clear
        FLT_ILLEGAL_RW    = 4'd2,       // w set without r
        FLT_A_ZERO        = 4'd3,
        FLT_R_ZERO        = 4'd4,       // load to a non readable page and mxr clear
        FLT_W_ZERO        = 4'd5,
        FLT_D_ZERO        = 4'd6,
        FLT_MISALIGNED_1G = 4'd7,
        FLT_MISALIGNED_2M = 4'd8,
        FLT_TOO_DEEP      = 4'd9        // no leaf found at the last level
    } pte_fault_e;

    // counter map, also the wishbone word address of each counter
    typedef enum logic [3:0] {
        EV_INVALID         = 4'd0,
        EV_ILLEGAL_RW      = 4'd1,
        EV_A_ZERO          = 4'd2,
        EV_R_ZERO          = 4'd3,
        EV_W_ZERO          = 4'd4,
        EV_D_ZERO          = 4'd5,
        EV_MISALIGNED_1G   = 4'd6,
        EV_MISALIGNED_2M   = 4'd7,
        EV_TOO_DEEP        = 4'd8,
        EV_COLL_DC_MISS    = 4'd9,
        EV_COLL_DC_HIT     = 4'd10,
        EV_COLL_DTLB_MISS  = 4'd11,
        EV_FLUSH_BRANCH    = 4'd12,
        EV_FLUSH_EXCEPTION = 4'd13,
        EV_FLUSH_INTERRUPT = 4'd14,
        EV_FLUSH_WHEN_FULL = 4'd15
    } ev_idx_e;

endpackage

`default_nettype wire

// ==== logic/pte_fault_classifier.sv ====
`timescale 1ns/1ps
`default_nettype none

module pte_fault_classifier
    import bemon_pkg::*;
(
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             pte_rd_valid_i,    // pte returned to the walker on a data walk
    input  logic             is_store_i,        // the walk serves a store
    input  logic             mxr_i,             // mstatus.mxr
    input  logic [1:0]       ptw_lvl_i,         // 1 is the root level, 3 the 4 KiB level
    input  logic [7:0]       pte_flags_i,
    input  logic [PPN_W-1:0] pte_ppn_i,
    output logic             fault_valid_o,
    output pte_fault_e       fault_cause_o
);

    logic       pte_v;
    logic       pte_r;
    logic       pte_w;
    logic       pte_x;
    logic       pte_a;
    logic       pte_d;
    logic       is_leaf;
    pte_fault_e cause_d;

    assign pte_v   = pte_flags_i[PTE_V_BIT];
    assign pte_r   = pte_flags_i[PTE_R_BIT];
    assign pte_w   = pte_flags_i[PTE_W_BIT];
    assign pte_x   = pte_flags_i[PTE_X_BIT];
    assign pte_a   = pte_flags_i[PTE_A_BIT];
    assign pte_d   = pte_flags_i[PTE_D_BIT];
    assign is_leaf = pte_r || pte_x;              // a pointer entry has neither r nor x

    // first matching check wins, the order follows the walker's own checks
    always_comb
    begin
        cause_d = FLT_NONE;
        if (!pte_v)
            cause_d = FLT_INVALID;
        else if (pte_w && !pte_r)
            cause_d = FLT_ILLEGAL_RW;
        else if (!is_leaf)
        begin
            if (ptw_lvl_i == 2'd3)
                cause_d = FLT_TOO_DEEP;             // pointer below the last level
        end
        else if (!pte_a)
            cause_d = FLT_A_ZERO;
        else if (!is_store_i && !pte_r && !mxr_i)
            cause_d = FLT_R_ZERO;                   // execute only page, mxr would make it readable
        else if (is_store_i && !pte_w)
            cause_d = FLT_W_ZERO;
        else if (is_store_i && !pte_d)
            cause_d = FLT_D_ZERO;                   // software has to set d before the store
        else if ((ptw_lvl_i == 2'd1) && (pte_ppn_i[17:0] != '0))
            cause_d = FLT_MISALIGNED_1G;
        else if ((ptw_lvl_i == 2'd2) && (pte_ppn_i[8:0] != '0))
            cause_d = FLT_MISALIGNED_2M;
    end

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            fault_valid_o <= 1'b0;
            fault_cause_o <= FLT_NONE;
        end
        else
        begin
            fault_valid_o <= pte_rd_valid_i && (cause_d != FLT_NONE);
            fault_cause_o <= pte_rd_valid_i ? cause_d : FLT_NONE;
        end
    end

endmodule

`default_nettype wire

// ==== logic/dtlb_occupancy.sv ====
`timescale 1ns/1ps
`default_nettype none

module dtlb_occupancy
    import bemon_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic [TLB_ENTRIES-1:0] tag_valid_i,
    input  logic [TLB_ENTRIES-1:0] tag_is_2m_i,
    input  logic [TLB_ENTRIES-1:0] tag_is_1g_i,
    input  logic                   dtlb_flush_i,
    output logic                   full_o,
    output logic                   full_4k_o,
    output logic                   full_2m_o,
    output logic                   all_sizes_o,
    output logic                   flush_when_full_o
);

    logic [TLB_ENTRIES-1:0] has_4k;
    logic [TLB_ENTRIES-1:0] has_2m;
    logic [TLB_ENTRIES-1:0] has_1g;
    logic                   full_d;

    // size bits of an invalid entry are stale, so each size is qualified by valid
    always_comb
    begin
        for (int e = 0; e < TLB_ENTRIES; e++)
        begin
            has_4k[e] = tag_valid_i[e] && !tag_is_2m_i[e] && !tag_is_1g_i[e];
            has_2m[e] = tag_valid_i[e] && tag_is_2m_i[e];
            has_1g[e] = tag_valid_i[e] && tag_is_1g_i[e];
        end
    end

    assign full_d = &tag_valid_i;

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            full_o            <= 1'b0;
            full_4k_o         <= 1'b0;
            full_2m_o         <= 1'b0;
            all_sizes_o       <= 1'b0;
            flush_when_full_o <= 1'b0;
        end
        else
        begin
            full_o            <= full_d;
            full_4k_o         <= &has_4k;
            full_2m_o         <= &has_2m;
            all_sizes_o       <= (|has_4k) && (|has_2m) && (|has_1g);
            flush_when_full_o <= dtlb_flush_i && full_d;    // flush sees the tags of its own cycle
        end
    end

endmodule

`default_nettype wire

// ==== logic/flush_collision_detector.sv ====
`timescale 1ns/1ps
`default_nettype none

module flush_collision_detector
    import bemon_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       dcache_miss_i,
    input  logic       dcache_hit_i,
    input  logic       dtlb_miss_i,
    input  logic       exe_branch_valid_i,     // branch resolved at execute
    input  logic       branch_mispredict_i,
    input  logic       stall_exe_i,
    input  logic       jal_id_i,               // unpredicted jal redirected at decode
    input  logic       csr_trap_i,
    input  logic       csr_cause_msb_i,        // interrupt bit of mcause
    output logic [2:0] collide_o,              // bit 0 dcache miss, 1 dcache hit, 2 dtlb miss
    output logic [2:0] flush_o                 // bit 0 branch, 1 exception, 2 interrupt
);

    logic                              branch_flush;
    logic                              exception_flush;
    logic                              interrupt_flush;
    logic                              any_flush;
    logic [2:0]                        mem_ev;
    logic [2:0][WINDOW_SIZE-2:0]       hist_q;     // the last WINDOW_SIZE-1 cycles per event
    logic [2:0]                        collide_d;

    assign branch_flush    = (exe_branch_valid_i && branch_mispredict_i && !stall_exe_i)
                             || jal_id_i;
    assign exception_flush = csr_trap_i && !csr_cause_msb_i;
    assign interrupt_flush = csr_trap_i && csr_cause_msb_i;
    assign any_flush       = branch_flush || exception_flush || interrupt_flush;

    assign mem_ev = {dtlb_miss_i, dcache_hit_i, dcache_miss_i};

    // an event in the flush cycle itself counts as distance zero
    always_comb
    begin
        for (int k = 0; k < 3; k++)
            collide_d[k] = any_flush && (mem_ev[k] || (|hist_q[k]));
    end

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            hist_q    <= '0;
            collide_o <= '0;
            flush_o   <= '0;
        end
        else
        begin
            for (int k = 0; k < 3; k++)
                hist_q[k] <= {hist_q[k][WINDOW_SIZE-3:0], mem_ev[k]};
            collide_o <= collide_d;
            flush_o   <= {interrupt_flush, exception_flush, branch_flush};
        end
    end

endmodule

`default_nettype wire

// ==== logic/event_stat_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module event_stat_regs
    import bemon_pkg::*;
(
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                fault_valid_i,
    input  pte_fault_e          fault_cause_i,
    input  logic [2:0]          collide_i,      // dcache miss, dcache hit, dtlb miss from bit 0
    input  logic [2:0]          flush_i,        // branch, exception, interrupt from bit 0
    input  logic                flush_when_full_i,
    input  logic                full_i,
    input  logic                full_4k_i,
    input  logic                full_2m_i,
    input  logic                all_sizes_i,
    input  logic                wb_cyc_i,
    input  logic                wb_stb_i,
    input  logic                wb_we_i,
    input  logic [WB_ADR_W-1:0] wb_adr_i,
    input  logic [WB_DAT_W-1:0] wb_dat_i,       // any write clears, the data itself is ignored
    output logic [WB_DAT_W-1:0] wb_dat_o,
    output logic                wb_ack_o
);

    logic [CNT_W-1:0]    cnt_q [16];
    logic [15:0]         inc;
    logic                wb_req;
    logic                adr_is_cnt;
    logic                clr;
    logic [WB_DAT_W-1:0] rd_data;

    // one increment line per counter, indexed by the counter map
    always_comb
    begin
        inc = '0;
        if (fault_valid_i)
        begin
            case (fault_cause_i)
                FLT_INVALID:       inc[EV_INVALID]       = 1'b1;
                FLT_ILLEGAL_RW:    inc[EV_ILLEGAL_RW]    = 1'b1;
                FLT_A_ZERO:        inc[EV_A_ZERO]        = 1'b1;
                FLT_R_ZERO:        inc[EV_R_ZERO]        = 1'b1;
                FLT_W_ZERO:        inc[EV_W_ZERO]        = 1'b1;
                FLT_D_ZERO:        inc[EV_D_ZERO]        = 1'b1;
                FLT_MISALIGNED_1G: inc[EV_MISALIGNED_1G] = 1'b1;
                FLT_MISALIGNED_2M: inc[EV_MISALIGNED_2M] = 1'b1;
                FLT_TOO_DEEP:      inc[EV_TOO_DEEP]      = 1'b1;
                default:           inc                   = '0;
            endcase
        end
        inc[EV_COLL_DC_MISS]    = collide_i[0];
        inc[EV_COLL_DC_HIT]     = collide_i[1];
        inc[EV_COLL_DTLB_MISS]  = collide_i[2];
        inc[EV_FLUSH_BRANCH]    = flush_i[0];
        inc[EV_FLUSH_EXCEPTION] = flush_i[1];
        inc[EV_FLUSH_INTERRUPT] = flush_i[2];
        inc[EV_FLUSH_WHEN_FULL] = flush_when_full_i;
    end

    assign wb_req     = wb_cyc_i && wb_stb_i && !wb_ack_o;   // classic cycle, one ack per strobe
    assign adr_is_cnt = (wb_adr_i[WB_ADR_W-1:4] == '0);
    assign clr        = wb_req && wb_we_i && adr_is_cnt;

    always_comb
    begin
        rd_data = '0;
        if (adr_is_cnt)
            rd_data[CNT_W-1:0] = cnt_q[wb_adr_i[3:0]];
        else if (wb_adr_i == WB_ADR_W'(STATUS_ADR))
            rd_data[3:0] = {full_i, full_4k_i, full_2m_i, all_sizes_i};  // full in bit 3
    end

    // a clear in the same cycle as an increment wins
    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            for (int i = 0; i < 16; i++)
                cnt_q[i] <= '0;
        end
        else
        begin
            for (int i = 0; i < 16; i++)
            begin
                if (clr && (wb_adr_i[3:0] == i))
                    cnt_q[i] <= '0;
                else if (inc[i] && (cnt_q[i] != '1))
                    cnt_q[i] <= cnt_q[i] + 1'b1;
            end
        end
    end

    // read data is captured with the request and held while ack is high
    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            wb_ack_o <= 1'b0;
            wb_dat_o <= '0;
        end
        else
        begin
            wb_ack_o <= wb_req;
            if (wb_req && !wb_we_i)
                wb_dat_o <= rd_data;
        end
    end

endmodule

`default_nettype wire

// ==== logic/backend_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

module backend_monitor
    import bemon_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    // page table walker
    input  logic                   pte_rd_valid_i,
    input  logic                   is_store_i,
    input  logic                   mxr_i,
    input  logic [1:0]             ptw_lvl_i,
    input  logic [7:0]             pte_flags_i,
    input  logic [PPN_W-1:0]       pte_ppn_i,
    // dtlb tags
    input  logic [TLB_ENTRIES-1:0] tag_valid_i,
    input  logic [TLB_ENTRIES-1:0] tag_is_2m_i,
    input  logic [TLB_ENTRIES-1:0] tag_is_1g_i,
    input  logic                   dtlb_flush_i,
    // memory events and pipeline flush sources
    input  logic                   dcache_miss_i,
    input  logic                   dcache_hit_i,
    input  logic                   dtlb_miss_i,
    input  logic                   exe_branch_valid_i,
    input  logic                   branch_mispredict_i,
    input  logic                   stall_exe_i,
    input  logic                   jal_id_i,
    input  logic                   csr_trap_i,
    input  logic                   csr_cause_msb_i,
    // wishbone classic slave
    input  logic                   wb_cyc_i,
    input  logic                   wb_stb_i,
    input  logic                   wb_we_i,
    input  logic [WB_ADR_W-1:0]    wb_adr_i,
    input  logic [WB_DAT_W-1:0]    wb_dat_i,
    output logic [WB_DAT_W-1:0]    wb_dat_o,
    output logic                   wb_ack_o
);

    logic       fault_valid;
    pte_fault_e fault_cause;
    logic       full;
    logic       full_4k;
    logic       full_2m;
    logic       all_sizes;
    logic       flush_when_full;
    logic [2:0] collide;
    logic [2:0] flush;

    pte_fault_classifier pte_fault_classifier_inst (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .pte_rd_valid_i (pte_rd_valid_i),
        .is_store_i     (is_store_i),
        .mxr_i          (mxr_i),
        .ptw_lvl_i      (ptw_lvl_i),
        .pte_flags_i    (pte_flags_i),
        .pte_ppn_i      (pte_ppn_i),
        .fault_valid_o  (fault_valid),
        .fault_cause_o  (fault_cause)
    );

    dtlb_occupancy dtlb_occupancy_inst (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .tag_valid_i       (tag_valid_i),
        .tag_is_2m_i       (tag_is_2m_i),
        .tag_is_1g_i       (tag_is_1g_i),
        .dtlb_flush_i      (dtlb_flush_i),
        .full_o            (full),
        .full_4k_o         (full_4k),
        .full_2m_o         (full_2m),
        .all_sizes_o       (all_sizes),
        .flush_when_full_o (flush_when_full)
    );

    flush_collision_detector flush_collision_detector_inst (
        .clk_i               (clk_i),
        .rst_n_i             (rst_n_i),
        .dcache_miss_i       (dcache_miss_i),
        .dcache_hit_i        (dcache_hit_i),
        .dtlb_miss_i         (dtlb_miss_i),
        .exe_branch_valid_i  (exe_branch_valid_i),
        .branch_mispredict_i (branch_mispredict_i),
        .stall_exe_i         (stall_exe_i),
        .jal_id_i            (jal_id_i),
        .csr_trap_i          (csr_trap_i),
        .csr_cause_msb_i     (csr_cause_msb_i),
        .collide_o           (collide),
        .flush_o             (flush)
    );

    event_stat_regs event_stat_regs_inst (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .fault_valid_i     (fault_valid),
        .fault_cause_i     (fault_cause),
        .collide_i         (collide),
        .flush_i           (flush),
        .flush_when_full_i (flush_when_full),
        .full_i            (full),
        .full_4k_i         (full_4k),
        .full_2m_i         (full_2m),
        .all_sizes_i       (all_sizes),
        .wb_cyc_i          (wb_cyc_i),
        .wb_stb_i          (wb_stb_i),
        .wb_we_i           (wb_we_i),
        .wb_adr_i          (wb_adr_i),
        .wb_dat_i          (wb_dat_i),
        .wb_dat_o          (wb_dat_o),
        .wb_ack_o          (wb_ack_o)
    );

endmodule

`default_nettype wire

// ==== verif/backend_monitor_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module backend_monitor_tb
    import bemon_pkg::*;
();

    localparam int MAX_ROWS = 128;
    localparam int K_READ   = 0;
    localparam int K_PTE    = 1;
    localparam int K_TLB    = 2;
    localparam int K_COLL   = 3;
    localparam int K_CLEAR  = 4;

    logic                   clk_i = 1'b0;
    logic                   rst_n_i;
    logic                   pte_rd_valid_i;
    logic                   is_store_i;
    logic                   mxr_i;
    logic [1:0]             ptw_lvl_i;
    logic [7:0]             pte_flags_i;
    logic [PPN_W-1:0]       pte_ppn_i;
    logic [TLB_ENTRIES-1:0] tag_valid_i;
    logic [TLB_ENTRIES-1:0] tag_is_2m_i;
    logic [TLB_ENTRIES-1:0] tag_is_1g_i;
    logic                   dtlb_flush_i;
    logic                   dcache_miss_i;
    logic                   dcache_hit_i;
    logic                   dtlb_miss_i;
    logic                   exe_branch_valid_i;
    logic                   branch_mispredict_i;
    logic                   stall_exe_i;
    logic                   jal_id_i;
    logic                   csr_trap_i;
    logic                   csr_cause_msb_i;
    logic                   wb_cyc_i;
    logic                   wb_stb_i;
    logic                   wb_we_i;
    logic [WB_ADR_W-1:0]    wb_adr_i;
    logic [WB_DAT_W-1:0]    wb_dat_i;
    logic [WB_DAT_W-1:0]    wb_dat_o;
    logic                   wb_ack_o;

    // stimulus table, one row per test
    int                     r_kind [MAX_ROWS];
    logic [63:0]            r_a    [MAX_ROWS];      // packed operands of the row
    logic [PPN_W-1:0]       r_ppn  [MAX_ROWS];
    logic [WB_ADR_W-1:0]    r_adr0 [MAX_ROWS];
    logic [WB_ADR_W-1:0]    r_adr1 [MAX_ROWS];
    logic [WB_DAT_W-1:0]    r_exp0 [MAX_ROWS];
    logic [WB_DAT_W-1:0]    r_exp1 [MAX_ROWS];
    int                     n_rows = 0;
    int                     mdl_cnt [16];            // expected counter contents
    logic [3:0]             mdl_status;
    logic [31:0]            lcg_state;
    int                     errors = 0;
    int                     fails = 0;
    logic                   row_ok;
    int                     cycles = 0;
    int                     cycle_limit = 200;

    backend_monitor backend_monitor_inst (
        .clk_i               (clk_i),
        .rst_n_i             (rst_n_i),
        .pte_rd_valid_i      (pte_rd_valid_i),
        .is_store_i          (is_store_i),
        .mxr_i               (mxr_i),
        .ptw_lvl_i           (ptw_lvl_i),
        .pte_flags_i         (pte_flags_i),
        .pte_ppn_i           (pte_ppn_i),
        .tag_valid_i         (tag_valid_i),
        .tag_is_2m_i         (tag_is_2m_i),
        .tag_is_1g_i         (tag_is_1g_i),
        .dtlb_flush_i        (dtlb_flush_i),
        .dcache_miss_i       (dcache_miss_i),
        .dcache_hit_i        (dcache_hit_i),
        .dtlb_miss_i         (dtlb_miss_i),
        .exe_branch_valid_i  (exe_branch_valid_i),
        .branch_mispredict_i (branch_mispredict_i),
        .stall_exe_i         (stall_exe_i),
        .jal_id_i            (jal_id_i),
        .csr_trap_i          (csr_trap_i),
        .csr_cause_msb_i     (csr_cause_msb_i),
        .wb_cyc_i            (wb_cyc_i),
        .wb_stb_i            (wb_stb_i),
        .wb_we_i             (wb_we_i),
        .wb_adr_i            (wb_adr_i),
        .wb_dat_i            (wb_dat_i),
        .wb_dat_o            (wb_dat_o),
        .wb_ack_o            (wb_ack_o)
    );

    always #50 clk_i = ~clk_i;

    always @(posedge clk_i)
    begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit)
        begin
            $display("timeout: the run did not finish within %0d clock cycles", cycle_limit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // sv39 walk rules, returns the fault cause number or 0
    function automatic int pte_expect(input int lvl, input bit store, input bit mxr,
                                      input logic [7:0] fl, input logic [PPN_W-1:0] ppn);
        if (!fl[0])
            return 1;
        if (fl[2] && !fl[1])
            return 2;
        if (!fl[1] && !fl[3])
            return (lvl == 3) ? 9 : 0;                // pointer entry
        if (!fl[6])
            return 3;
        if (!store && !fl[1] && !mxr)
            return 4;
        if (store && !fl[2])
            return 5;
        if (store && !fl[7])
            return 6;
        if (lvl == 1 && ppn[17:0] != 0)
            return 7;
        if (lvl == 2 && ppn[8:0] != 0)
            return 8;
        return 0;
    endfunction

    // status word bits are full, full_4k, full_2m, all_sizes from bit 3 down
    function automatic logic [3:0] occ_expect(input logic [TLB_ENTRIES-1:0] vld,
                                              input logic [TLB_ENTRIES-1:0] m2,
                                              input logic [TLB_ENTRIES-1:0] g1);
        int n_v;
        int n_4k;
        int n_2m;
        int n_1g;
        n_v = 0;
        n_4k = 0;
        n_2m = 0;
        n_1g = 0;
        for (int e = 0; e < TLB_ENTRIES; e++)
        begin
            n_v += vld[e];
            n_4k += vld[e] && !m2[e] && !g1[e];
            n_2m += vld[e] && m2[e];
            n_1g += vld[e] && g1[e];
        end
        return {n_v == TLB_ENTRIES, n_4k == TLB_ENTRIES, n_2m == TLB_ENTRIES,
                n_4k > 0 && n_2m > 0 && n_1g > 0};
    endfunction

    // flush kinds: 0 mispredict, 1 jal, 2 stalled mispredict, 3 exception, 4 interrupt,
    // 5 branch resolved without mispredict
    function automatic int flush_index(input int fk);
        case (fk)
            0, 1:    return EV_FLUSH_BRANCH;
            3:       return EV_FLUSH_EXCEPTION;
            4:       return EV_FLUSH_INTERRUPT;
            default: return -1;                       // no flush at all
        endcase
    endfunction

    function automatic string kind_name(input int kind);
        case (kind)
            K_READ:  return "read";
            K_PTE:   return "pte";
            K_TLB:   return "dtlb";
            K_COLL:  return "collision";
            default: return "clear";
        endcase
    endfunction

    task automatic add_read(input int adr);
        r_kind[n_rows] = K_READ;
        r_adr0[n_rows] = adr[WB_ADR_W-1:0];
        if (adr == STATUS_ADR)
            r_exp0[n_rows] = {28'h0, mdl_status};
        else
            r_exp0[n_rows] = mdl_cnt[adr];
        n_rows++;
    endtask

    task automatic add_pte(input int lvl, input bit store, input bit mxr,
                           input logic [7:0] flags, input int ppn_mode);
        logic [31:0]      lo;
        logic [31:0]      hi;
        logic [PPN_W-1:0] ppn;
        logic [7:0]       fl;
        logic [63:0]      a;
        int               cause;
        lo = lcg_next();
        hi = lcg_next();
        ppn = {hi[PPN_W-33:0], lo};
        if (ppn_mode == 1)
            ppn[17:0] = '0;                           // 1 GiB aligned
        else if (ppn_mode == 2)
            ppn[8:0] = '0;                            // 2 MiB aligned
        fl = flags | {2'b00, hi[31:30], 4'b0000};     // u and g bits are don't care
        cause = pte_expect(lvl, store, mxr, fl, ppn);
        if (cause != 0)
            mdl_cnt[cause-1]++;
        a = '0;
        a[7:0] = fl;
        a[8] = mxr;
        a[9] = store;
        a[11:10] = lvl[1:0];
        r_kind[n_rows] = K_PTE;
        r_a[n_rows] = a;
        r_ppn[n_rows] = ppn;
        r_adr0[n_rows] = (cause == 0) ? 5'd0 : 5'(cause - 1);
        r_exp0[n_rows] = mdl_cnt[(cause == 0) ? 0 : cause - 1];
        n_rows++;
    endtask

    task automatic add_tlb(input logic [TLB_ENTRIES-1:0] vld, input logic [TLB_ENTRIES-1:0] m2,
                           input logic [TLB_ENTRIES-1:0] g1, input bit flush);
        logic [63:0] a;
        mdl_status = occ_expect(vld, m2, g1);
        if (flush && mdl_status[3])
            mdl_cnt[EV_FLUSH_WHEN_FULL]++;
        a = '0;
        a[7:0] = vld;
        a[15:8] = m2;
        a[23:16] = g1;
        a[24] = flush;
        r_kind[n_rows] = K_TLB;
        r_a[n_rows] = a;
        r_adr0[n_rows] = WB_ADR_W'(STATUS_ADR);
        r_exp0[n_rows] = {28'h0, mdl_status};
        r_adr1[n_rows] = EV_FLUSH_WHEN_FULL;
        r_exp1[n_rows] = mdl_cnt[EV_FLUSH_WHEN_FULL];
        n_rows++;
    endtask

    task automatic add_coll(input int cls, input int d, input int fk);
        logic [63:0] a;
        int          fidx;
        fidx = flush_index(fk);
        if (fidx >= 0 && d < WINDOW_SIZE)
            mdl_cnt[9+cls]++;
        if (fidx >= 0)
            mdl_cnt[fidx]++;
        else
            fidx = EV_FLUSH_BRANCH;                   // must stay unchanged
        a = '0;
        a[1:0] = cls[1:0];
        a[15:8] = d[7:0];
        a[23:16] = fk[7:0];
        r_kind[n_rows] = K_COLL;
        r_a[n_rows] = a;
        r_adr0[n_rows] = 5'(9 + cls);
        r_exp0[n_rows] = mdl_cnt[9+cls];
        r_adr1[n_rows] = 5'(fidx);
        r_exp1[n_rows] = mdl_cnt[fidx];
        n_rows++;
    endtask

    task automatic add_clear(input int adr);
        mdl_cnt[adr] = 0;
        r_kind[n_rows] = K_CLEAR;
        r_adr0[n_rows] = adr[WB_ADR_W-1:0];
        n_rows++;
    endtask

    task automatic build_table();
        for (int i = 0; i < 16; i++)
            mdl_cnt[i] = 0;
        mdl_status = 4'h0;
        for (int i = 0; i < 16; i++)
            add_read(i);
        add_read(STATUS_ADR);
        add_pte(3, 0, 0, 8'h00, 0);
        add_pte(2, 1, 0, 8'hc4, 0);
        add_pte(3, 0, 0, 8'h05, 0);
        add_pte(1, 1, 1, 8'hc5, 0);
        add_pte(3, 0, 0, 8'h01, 0);
        add_pte(3, 1, 0, 8'hc1, 0);
        add_pte(1, 0, 0, 8'h01, 0);
        add_pte(2, 1, 0, 8'h01, 0);
        add_pte(3, 0, 0, 8'h83, 0);
        add_pte(3, 0, 0, 8'h49, 0);
        add_pte(3, 0, 1, 8'h49, 0);
        add_pte(3, 1, 0, 8'h4b, 0);
        add_pte(3, 1, 0, 8'h47, 0);
        add_pte(3, 1, 0, 8'hc7, 0);
        add_pte(1, 0, 0, 8'h43, 0);
        add_pte(1, 0, 0, 8'h43, 1);
        add_pte(2, 1, 0, 8'hc7, 0);
        add_pte(2, 0, 0, 8'h43, 2);
        add_pte(2, 0, 1, 8'h49, 1);
        add_pte(1, 1, 0, 8'h43, 0);
        add_tlb(8'hff, 8'h00, 8'h00, 1);
        add_tlb(8'h7f, 8'h00, 8'h00, 1);
        add_tlb(8'hff, 8'hff, 8'h00, 0);
        add_tlb(8'hff, 8'h0f, 8'h10, 1);
        add_tlb(8'h0b, 8'h02, 8'h08, 1);
        add_tlb(8'h03, 8'h04, 8'h08, 0);
        add_tlb(8'hff, 8'h80, 8'h80, 1);
        add_tlb(8'h00, 8'hff, 8'h00, 1);
        for (int c = 0; c < 3; c++)
        begin
            for (int d = 0; d <= 6; d++)
                add_coll(c, d, (c + d) % 6);
        end
        add_clear(EV_FLUSH_BRANCH);
        add_clear(EV_R_ZERO);
        add_clear(EV_COLL_DC_MISS);
        for (int i = 0; i < 16; i++)
            add_read(i);
        add_read(STATUS_ADR);
    endtask

    task automatic wb_access(input logic we, input logic [WB_ADR_W-1:0] adr,
                             output logic [WB_DAT_W-1:0] data);
        repeat (4) @(negedge clk_i);                  // lets pending events reach the counters
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i = we;
        wb_adr_i = adr;
        wb_dat_i = we ? '1 : '0;                      // a clear ignores the write data
        @(negedge clk_i);
        while (!wb_ack_o)
            @(negedge clk_i);
        data = wb_dat_o;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i = 1'b0;
    endtask

    task automatic check_value(input int row, input logic [WB_ADR_W-1:0] adr,
                               input logic [WB_DAT_W-1:0] got, input logic [WB_DAT_W-1:0] exp);
        assert (got === exp)
        else
        begin
            $display("error at %0t ns: row %0d address %0d read 0x%h, expected 0x%h",
                     $time, row, adr, got, exp);
            errors++;
            row_ok = 1'b0;
        end
    endtask

    task automatic drive_mem(input int cls, input bit on);
        dcache_miss_i = on && (cls == 0);
        dcache_hit_i = on && (cls == 1);
        dtlb_miss_i = on && (cls == 2);
    endtask

    task automatic drive_flush(input int fk, input bit on);
        exe_branch_valid_i = on && (fk == 0 || fk == 2 || fk == 5);
        branch_mispredict_i = on && (fk == 0 || fk == 2);
        stall_exe_i = on && (fk == 2);
        jal_id_i = on && (fk == 1);
        csr_trap_i = on && (fk == 3 || fk == 4);
        csr_cause_msb_i = on && (fk == 4);
    endtask

    task automatic run_row(input int i);
        logic [63:0]         a;
        logic [WB_DAT_W-1:0] got;
        int                  d;
        a = r_a[i];
        d = a[15:8];
        row_ok = 1'b1;
        case (r_kind[i])
            K_PTE:
            begin
                pte_flags_i = a[7:0];
                mxr_i = a[8];
                is_store_i = a[9];
                ptw_lvl_i = a[11:10];
                pte_ppn_i = r_ppn[i];
                pte_rd_valid_i = 1'b1;
                @(negedge clk_i);
                pte_rd_valid_i = 1'b0;
            end
            K_TLB:
            begin
                tag_valid_i = a[7:0];                 // tags stay until the next pattern
                tag_is_2m_i = a[15:8];
                tag_is_1g_i = a[23:16];
                dtlb_flush_i = a[24];
                @(negedge clk_i);
                dtlb_flush_i = 1'b0;
            end
            K_COLL:
            begin
                for (int k = 0; k <= d; k++)
                begin
                    drive_mem(a[1:0], k == 0);
                    drive_flush(a[23:16], k == d);
                    @(negedge clk_i);
                end
                drive_mem(0, 1'b0);
                drive_flush(0, 1'b0);
            end
            default:
                ;
        endcase
        if (r_kind[i] == K_CLEAR)
            wb_access(1'b1, r_adr0[i], got);
        else
        begin
            wb_access(1'b0, r_adr0[i], got);
            check_value(i, r_adr0[i], got, r_exp0[i]);
        end
        if (r_kind[i] == K_TLB || r_kind[i] == K_COLL)
        begin
            wb_access(1'b0, r_adr1[i], got);
            check_value(i, r_adr1[i], got, r_exp1[i]);
        end
        if (!row_ok)
            fails++;
        $display("row %0d %s: %s", i, kind_name(r_kind[i]), row_ok ? "ok" : "mismatch");
    endtask

    initial
    begin
        rst_n_i = 1'b0;
        pte_rd_valid_i = 1'b0;
        is_store_i = 1'b0;
        mxr_i = 1'b0;
        ptw_lvl_i = 2'd0;
        pte_flags_i = '0;
        pte_ppn_i = '0;
        tag_valid_i = '0;
        tag_is_2m_i = '0;
        tag_is_1g_i = '0;
        dtlb_flush_i = 1'b0;
        drive_mem(0, 1'b0);
        drive_flush(0, 1'b0);
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        lcg_state = 32'h8744_3c0a;
        build_table();
        cycle_limit = 20 * n_rows + 200;
        repeat (16) @(negedge clk_i);
        rst_n_i = 1'b1;
        for (int i = 0; i < n_rows; i++)
            run_row(i);
        $display("rows %0d, failed rows %0d, errors %0d", n_rows, fails, errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
logic/bemon_pkg.sv
logic/pte_fault_classifier.sv
logic/dtlb_occupancy.sv
logic/flush_collision_detector.sv
logic/event_stat_regs.sv
logic/backend_monitor.sv
verif/backend_monitor_tb.sv
